//--- verilog/fir_consts.svh
`ifndef FIR_CONSTS_SVH
`define FIR_CONSTS_SVH

// filter shape
`define FIR_TAPS        11
`define FIR_DATA_W      32

// configuration port
`define FIR_ADDR_W      12
`define FIR_LEN_W       10

// register map
`define FIR_ADDR_CTRL   12'h000     // bit 0 starts a block
`define FIR_ADDR_LEN    12'h010     // samples per block
`define FIR_ADDR_COEF   12'h040     // coefficient k at base + 4k

`endif

//--- verilog/fir_pkg.sv
`default_nettype none

package fir_pkg;

`include "fir_consts.svh"

    typedef logic [`FIR_DATA_W-1:0] sample_t;
    typedef logic [`FIR_DATA_W-1:0] coef_t;
    typedef logic [`FIR_DATA_W-1:0] acc_t;     // wraps mod 2^32
    typedef logic [3:0]             tap_idx_t;
    typedef logic [`FIR_LEN_W-1:0]  blk_len_t;
    typedef logic [`FIR_ADDR_W-1:0] cfg_addr_t;

    typedef struct packed {
        cfg_addr_t              addr;
        logic [`FIR_DATA_W-1:0] data;
    } cfg_write_t;

    typedef struct packed {
        sample_t sample;
        logic    last;
    } sample_beat_t;                           // broadcast to every cell

    typedef struct packed {
        acc_t sum;
        logic last;
    } result_beat_t;

    typedef enum logic [0:0] {
        BLK_IDLE,
        BLK_RUN
    } blk_state_t;

endpackage

`default_nettype wire

//--- verilog/fir_cfg_regs.sv
`default_nettype none

`include "fir_consts.svh"

module fir_cfg_regs (
    input  wire                     axis_clk,
    input  wire                     axis_rst_n,
    input  wire                     cfg_valid,
    input  fir_pkg::cfg_write_t     cfg_write,
    input  wire                     busy,
    output logic                    cfg_ready,
    output logic                    start,
    output fir_pkg::blk_len_t       blk_len,
    output logic [`FIR_TAPS-1:0]    coef_we,
    output fir_pkg::coef_t          coef_data
);

    import fir_pkg::*;

    logic      cfg_hs;
    cfg_addr_t coef_offset;
    tap_idx_t  coef_idx;
    logic      coef_hit;

    assign cfg_ready = !busy;                  // no writes while a block runs
    assign cfg_hs    = cfg_valid && cfg_ready;

    // coefficient window decode
    assign coef_offset = cfg_write.addr - cfg_addr_t'(`FIR_ADDR_COEF);
    assign coef_idx    = coef_offset[5:2];
    assign coef_hit    = cfg_hs
                      && (cfg_write.addr >= cfg_addr_t'(`FIR_ADDR_COEF))
                      && (coef_offset[1:0] == 2'b00)
                      && (coef_offset[`FIR_ADDR_W-1:2] < `FIR_TAPS);

    always_comb begin
        coef_we = '0;
        if (coef_hit) begin
            coef_we[coef_idx] = 1'b1;          // one-hot into the cells
        end
    end

    assign coef_data = cfg_write.data;

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            start   <= 1'b0;
            blk_len <= '0;
        end else begin
            start <= cfg_hs && (cfg_write.addr == cfg_addr_t'(`FIR_ADDR_CTRL))
                  && cfg_write.data[0];
            if (cfg_hs && (cfg_write.addr == cfg_addr_t'(`FIR_ADDR_LEN))) begin
                blk_len <= cfg_write.data[`FIR_LEN_W-1:0];
            end
        end
    end

    // the ingress must report busy from the start pulse on
    a_busy_on_start: assert property (
        @(posedge axis_clk) disable iff (!axis_rst_n)
        start |-> busy
    );

endmodule

`default_nettype wire

//--- verilog/fir_sample_ingress.sv
`default_nettype none

module fir_sample_ingress (
    input  wire                     axis_clk,
    input  wire                     axis_rst_n,
    input  wire                     start,
    input  fir_pkg::blk_len_t       blk_len,
    input  wire                     ss_tvalid,
    input  fir_pkg::sample_t        ss_tdata,
    input  wire                     slot_free,
    output logic                    ss_tready,
    output logic                    busy,
    output logic                    advance,
    output logic                    clear,
    output fir_pkg::sample_beat_t   beat
);

    import fir_pkg::*;

    blk_state_t state;
    blk_len_t   count;                         // samples taken so far in this block
    logic       last_sample;

    assign ss_tready   = (state == BLK_RUN) && slot_free;
    assign advance     = ss_tvalid && ss_tready;
    assign clear       = (state == BLK_IDLE) && start;
    assign busy        = (state == BLK_RUN) || start;   // covers the start cycle too
    assign last_sample = (blk_len_t'(count + 1'b1) == blk_len);

    assign beat.sample = ss_tdata;
    assign beat.last   = last_sample;

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            state <= BLK_IDLE;
            count <= '0;
        end else begin
            case (state)
                BLK_IDLE: begin
                    if (start) begin
                        state <= BLK_RUN;
                        count <= '0;
                    end
                end
                BLK_RUN: begin
                    if (advance) begin
                        count <= count + 1'b1;
                        if (last_sample) begin
                            state <= BLK_IDLE;         // block ends on its last handshake
                        end
                    end
                end
                default: begin
                    state <= BLK_IDLE;
                end
            endcase
        end
    end

    // a zero-length block would never terminate
    a_len_nonzero: assert property (
        @(posedge axis_clk) disable iff (!axis_rst_n)
        clear |-> (blk_len != '0)
    );

    // the counter stays below the length for the whole block
    a_count_in_range: assert property (
        @(posedge axis_clk) disable iff (!axis_rst_n)
        (state == BLK_RUN) |-> (count < blk_len)
    );

endmodule

`default_nettype wire

//--- verilog/fir_tap_cell.sv
`default_nettype none

module fir_tap_cell (
    input  wire                     axis_clk,
    input  wire                     axis_rst_n,
    input  wire                     coef_we,
    input  fir_pkg::coef_t          coef_data,
    input  wire                     advance,
    input  wire                     clear,
    input  fir_pkg::sample_beat_t   beat,
    input  fir_pkg::acc_t           psum_in,
    output fir_pkg::acc_t           psum_next,
    output fir_pkg::acc_t           psum
);

    import fir_pkg::*;

    coef_t coef;

    // 32-bit context, so the product and sum both wrap
    assign psum_next = acc_t'(coef * beat.sample + psum_in);

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            coef <= '0;
        end else if (coef_we) begin
            coef <= coef_data;
        end
    end

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            psum <= '0;
        end else if (clear) begin
            psum <= '0;                        // drop history of the previous block
        end else if (advance) begin
            psum <= psum_next;
        end
    end

endmodule

`default_nettype wire

//--- verilog/fir_result_egress.sv
`default_nettype none

module fir_result_egress (
    input  wire                     axis_clk,
    input  wire                     axis_rst_n,
    input  wire                     advance,
    input  fir_pkg::result_beat_t   result,
    input  wire                     sm_tready,
    output logic                    slot_free,
    output logic                    sm_tvalid,
    output fir_pkg::acc_t           sm_tdata,
    output logic                    sm_tlast
);

    import fir_pkg::*;

    logic         full;
    result_beat_t slot;

    assign slot_free = !full || sm_tready;     // empty, or draining this cycle
    assign sm_tvalid = full;
    assign sm_tdata  = slot.sum;
    assign sm_tlast  = slot.last;

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            full <= 1'b0;
        end else if (advance) begin
            full <= 1'b1;                      // fill wins over a same-edge drain
        end else if (sm_tready) begin
            full <= 1'b0;
        end
    end

    always_ff @(posedge axis_clk) begin
        if (advance) begin
            slot <= result;
        end
    end

    a_hold_while_stalled: assert property (
        @(posedge axis_clk) disable iff (!axis_rst_n)
        (sm_tvalid && !sm_tready) |=> (sm_tvalid && $stable(sm_tdata) && $stable(sm_tlast))
    );

endmodule

`default_nettype wire

//--- verilog/fir_top.sv
`default_nettype none

`include "fir_consts.svh"

module fir_top (
    input  wire                     axis_clk,
    input  wire                     axis_rst_n,
    // configuration
    input  wire                     cfg_valid,
    output logic                    cfg_ready,
    input  fir_pkg::cfg_write_t     cfg_write,
    // sample stream
    input  wire                     ss_tvalid,
    output logic                    ss_tready,
    input  fir_pkg::sample_t        ss_tdata,
    // result stream
    output logic                    sm_tvalid,
    input  wire                     sm_tready,
    output fir_pkg::acc_t           sm_tdata,
    output logic                    sm_tlast
);

    import fir_pkg::*;

    logic                 start;
    blk_len_t             blk_len;
    logic [`FIR_TAPS-1:0] coef_we;
    coef_t                coef_data;
    logic                 busy;
    logic                 advance;
    logic                 clear;
    sample_beat_t         beat;
    logic                 slot_free;
    acc_t                 psum_chain [`FIR_TAPS+1];   // entry k is the psum of cell k
    acc_t                 next_sum   [`FIR_TAPS];
    result_beat_t         result;

    assign psum_chain[`FIR_TAPS] = '0;              // beyond the last tap
    assign result.sum  = next_sum[0];
    assign result.last = beat.last;

    fir_cfg_regs u_cfg (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .cfg_valid  (cfg_valid),
        .cfg_write  (cfg_write),
        .busy       (busy),
        .cfg_ready  (cfg_ready),
        .start      (start),
        .blk_len    (blk_len),
        .coef_we    (coef_we),
        .coef_data  (coef_data)
    );

    fir_sample_ingress u_ingress (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .start      (start),
        .blk_len    (blk_len),
        .ss_tvalid  (ss_tvalid),
        .ss_tdata   (ss_tdata),
        .slot_free  (slot_free),
        .ss_tready  (ss_tready),
        .busy       (busy),
        .advance    (advance),
        .clear      (clear),
        .beat       (beat)
    );

    // transposed chain, cell 0 produces the output
    for (genvar k = 0; k < `FIR_TAPS; k++) begin : g_tap
        fir_tap_cell u_cell (
            .axis_clk   (axis_clk),
            .axis_rst_n (axis_rst_n),
            .coef_we    (coef_we[k]),
            .coef_data  (coef_data),
            .advance    (advance),
            .clear      (clear),
            .beat       (beat),
            .psum_in    (psum_chain[k+1]),
            .psum_next  (next_sum[k]),
            .psum       (psum_chain[k])
        );
    end

    fir_result_egress u_egress (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .advance    (advance),
        .result     (result),
        .sm_tready  (sm_tready),
        .slot_free  (slot_free),
        .sm_tvalid  (sm_tvalid),
        .sm_tdata   (sm_tdata),
        .sm_tlast   (sm_tlast)
    );

endmodule

`default_nettype wire

//--- tests/fir_tb.sv
`default_nettype none

module fir_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import fir_pkg::*;

    localparam string TRACE_PATH = "tests/fir_trace.txt";

    logic         axis_clk;
    logic         axis_rst_n;
    logic         cfg_valid;
    logic         cfg_ready;
    cfg_write_t   cfg_write;
    logic         ss_tvalid;
    logic         ss_tready;
    sample_t      ss_tdata;
    logic         sm_tvalid;
    logic         sm_tready;
    acc_t         sm_tdata;
    logic         sm_tlast;

    result_beat_t expected_q[$];               // results the DUT still owes
    result_beat_t seen;
    result_beat_t held;                        // output captured on a stalled cycle
    logic         stalled = 1'b0;
    logic [31:0]  lfsr_state = 32'h4886_7566;
    int unsigned  cycle_count = 0;
    int unsigned  cycle_limit = 0;

    fir_top dut0 (.*);

    assign seen = {sm_tdata, sm_tlast};

    initial begin
        axis_clk = 1'b0;
        forever #5 axis_clk = ~axis_clk;
    end

    task automatic stop_on_failure(input string reason);
        $display("%s", reason);
        $display("Checks failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_result(input string tag, input result_beat_t got,
                                input result_beat_t want);
        if (got.sum !== want.sum) begin
            stop_on_failure($sformatf("** Error: sm_tdata (%s) = %h, expected %h",
                                      tag, got.sum, want.sum));
        end
        if (got.last !== want.last) begin
            stop_on_failure($sformatf("** Error: sm_tlast (%s) = %h, expected %h",
                                      tag, got.last, want.last));
        end
    endtask

    task automatic check_flag(input string name, input bit got, input bit want);
        if (got !== want) begin
            stop_on_failure($sformatf("** Error: %s = %h, expected %h", name, got, want));
        end
    endtask

    // right-shift Galois form with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic [31:0] shifted;
        shifted = state >> 1;
        if (state[0]) begin
            shifted = shifted ^ 32'h8020_0003;
        end
        return shifted;
    endfunction

    function automatic int unsigned count_trace_lines();
        int               fd;
        int unsigned      lines;
        logic [8*160-1:0] line_buf;
        lines = 0;
        fd = $fopen(TRACE_PATH, "r");
        if (fd != 0) begin
            while ($fgets(line_buf, fd) != 0) begin
                lines++;
            end
            $fclose(fd);
        end
        return lines;
    endfunction

    // called 1 ns after a rising edge and returns 1 ns after the handshake edge
    task automatic write_config(input cfg_addr_t addr, input logic [31:0] data);
        cfg_write.addr = addr;
        cfg_write.data = data;
        cfg_valid      = 1'b1;
        @(negedge axis_clk);
        while (!cfg_ready) begin
            @(negedge axis_clk);
        end
        @(posedge axis_clk);
        #1;
        cfg_valid = 1'b0;
        cfg_write = '0;
    endtask

    task automatic send_sample(input sample_t data);
        ss_tdata  = data;
        ss_tvalid = 1'b1;
        @(negedge axis_clk);
        while (!ss_tready) begin
            @(negedge axis_clk);
        end
        check_flag("cfg_ready", cfg_ready, 1'b0);  // block is running
        @(posedge axis_clk);
        #1;
        ss_tvalid = 1'b0;
    endtask

    // random back-pressure from one LFSR bit per cycle
    always @(posedge axis_clk) begin
        #1;
        sm_tready  = lfsr_state[0];
        lfsr_state = lfsr_next(lfsr_state);
    end

    // outputs are settled at the falling edge
    always @(negedge axis_clk) begin
        if (axis_rst_n) begin
            if (stalled) begin
                check_flag("sm_tvalid", sm_tvalid, 1'b1);
                check_result("held", seen, held);
            end
            if (sm_tvalid && sm_tready) begin
                if (expected_q.size() == 0) begin
                    stop_on_failure("the DUT produced a result that the trace does not expect");
                end else begin
                    check_result("result", seen, expected_q.pop_front());
                end
            end
            stalled = sm_tvalid && !sm_tready;
            held    = seen;
        end
    end

    always @(posedge axis_clk) begin
        cycle_count <= cycle_count + 1;
        if ((cycle_limit != 0) && (cycle_count >= cycle_limit)) begin
            stop_on_failure($sformatf("timeout, no end of test after %0d cycles", cycle_count));
        end
    end

    initial begin
        int          fd;
        int          code;
        logic [7:0]  kind;
        logic [31:0] word_a;
        logic [31:0] word_b;
        logic [8*160-1:0] line_buf;

        axis_rst_n = 1'b0;
        cfg_valid  = 1'b0;
        cfg_write  = '0;
        ss_tvalid  = 1'b0;
        ss_tdata   = '0;
        sm_tready  = 1'b0;
        cycle_limit = 20 * count_trace_lines();
        fd = $fopen(TRACE_PATH, "r");
        if (fd == 0) begin
            stop_on_failure("cannot open the trace file tests/fir_trace.txt");
        end

        repeat (2) @(posedge axis_clk);
        #1;
        axis_rst_n = 1'b1;
        @(negedge axis_clk);
        check_flag("cfg_ready", cfg_ready, 1'b1);
        check_flag("ss_tready", ss_tready, 1'b0);
        check_flag("sm_tvalid", sm_tvalid, 1'b0);
        @(posedge axis_clk);
        #1;

        code = $fscanf(fd, " %c", kind);
        while (code == 1) begin
            case (kind)
                "#": begin
                    code = $fgets(line_buf, fd);   // column notes
                end
                "C": begin
                    code = $fscanf(fd, "%h %h", word_a, word_b);
                    if (code != 2) begin
                        stop_on_failure("malformed configuration record in the trace");
                    end
                    write_config(word_a[11:0], word_b);
                end
                "S": begin
                    code = $fscanf(fd, "%h", word_a);
                    if (code != 1) begin
                        stop_on_failure("malformed sample record in the trace");
                    end
                    send_sample(word_a);
                end
                "E": begin
                    code = $fscanf(fd, "%h %h", word_a, word_b);
                    if (code != 2) begin
                        stop_on_failure("malformed expected-result record in the trace");
                    end
                    expected_q.push_back(result_beat_t'{word_a, word_b[0]});
                end
                default: begin
                    stop_on_failure($sformatf("unknown record kind '%c' in the trace", kind));
                end
            endcase
            code = $fscanf(fd, " %c", kind);
        end
        $fclose(fd);

        while (expected_q.size() != 0) begin
            @(negedge axis_clk);
        end
        @(negedge axis_clk);
        check_flag("sm_tvalid", sm_tvalid, 1'b0);
        check_flag("cfg_ready", cfg_ready, 1'b1);

        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/fir_trace.txt
# C addr data = configuration write, S data = sample, E data last = expected result
# all fields in hex, one record per line
C 040 80000000
C 044 00000002
C 048 00000003
C 04C 00000004
C 050 00000005
C 054 00000006
C 058 00000007
C 05C 00000008
C 060 00000009
C 064 0000000A
C 068 FFFFFFFF
C 010 00000010
C 000 00000001
S 00000001
E 80000000 0
S 00000002
E 00000002 0
S 00000003
E 80000007 0
S 00000004
E 00000010 0
S 00000005
E 8000001E 0
S 00000006
E 00000032 0
S 00000007
E 8000004D 0
S 00000008
E 00000070 0
S 00000009
E 8000009C 0
S 0000000A
E 000000D2 0
S 0000000B
E 80000107 0
S 0000000C
E 0000013C 0
S 0000000D
E 80000171 0
S 0000000E
E 000001A6 0
S 0000000F
E 800001DB 0
S 00000010
E 00000210 1
C 040 00000001
C 044 00010000
C 010 00000005
C 000 00000001
S 00010000
E 00010000 0
S FFFFFFFF
E FFFFFFFF 0
S 00000002
E 00020002 0
S 00000100
E 000600FD 0
S 00000001
E 01050003 1
C 040 00000002
C 06C DEADBEEF
C 010 00000003
C 000 00000001
S 00000005
E 0000000A 0
S 00000007
E 0005000E 0
S 00000009
E 00070021 1

//--- vlog.f
+incdir+verilog
verilog/fir_pkg.sv
verilog/fir_cfg_regs.sv
verilog/fir_sample_ingress.sv
verilog/fir_tap_cell.sv
verilog/fir_result_egress.sv
verilog/fir_top.sv
tests/fir_tb.sv

//--- run.sh
#!/bin/sh
# compile and run the FIR testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/100ps \
    -f vlog.f --top-module fir_tb -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit $status
fi

./obj_dir/Vfir_tb
status=$?
if [ $status -ne 0 ]; then
    echo "simulation ended with status $status"
    exit $status
fi
exit 0
